// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_castle
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/castle_pkg.sv
// castle demo shared definitions
// raster and framebuffer sizes, palette, scene and bus types
package castle_pkg;
    typedef logic signed [7:0] coord_t;  // screen or framebuffer coordinate
    typedef logic [3:0]        cidx_t;   // colour index

    localparam int FB_WIDTH  = 64;
    localparam int FB_HEIGHT = 48;
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = $clog2(FB_DEPTH);

    localparam int H_TOTAL      = 80;  // includes blanking
    localparam int V_TOTAL      = 56;
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_END   = 72;
    localparam int V_SYNC_START = 50;
    localparam int V_SYNC_END   = 52;

    localparam int SHAPE_CNT = 9;

    // 12-bit rgb per index
    localparam logic [11:0] PALETTE [16] = '{
        12'h000, 12'h235, 12'h725, 12'h085,  // black, dark blue, dark purple, dark green
        12'hA53, 12'h655, 12'hCCC, 12'hFFF,  // brown, dark grey, light grey, white
        12'hF05, 12'hFA0, 12'hFE2, 12'h0E3,
        12'h2AF, 12'h879, 12'hF7A, 12'hFCA
    };

    typedef enum logic {SHAPE_RECT, SHAPE_TRI} shape_kind_e;
    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} seq_state_e;

    typedef struct packed {
        shape_kind_e kind;
        coord_t      x0, y0;
        coord_t      x1, y1;
        coord_t      x2, y2;  // unused for rectangles
        cidx_t       cidx;
    } shape_t;

    typedef struct packed {
        logic   we;
        coord_t x, y;
        cidx_t  cidx;
    } fb_write_t;

    typedef struct packed {
        coord_t sx, sy;
        logic   hsync, vsync, de, frame;
    } screen_pos_t;

    typedef struct packed {
        logic       hsync, vsync, de;
        logic [3:0] r, g, b;
    } vga_out_t;
endpackage

// File: hw/castle_top.sv
// castle drawing top level
// sequencer and fillers draw the scene into the framebuffer, scanned out as vga
`timescale 1ns/1ns

module castle_top import castle_pkg::*; (
    input  logic     clk_100m,
    input  logic     reset,
    output vga_out_t vga,
    output logic     scene_done
);
    screen_pos_t pos;
    shape_t      shape;
    fb_write_t   fb_wr;
    logic        busy, draw_oe;
    logic        rect_start, rect_drawing, rect_done;
    logic        tri_start, tri_drawing, tri_done;
    coord_t      rect_x, rect_y, tri_x, tri_y;

    display_timing display_timing_i (.clk_100m, .reset, .pos);

    scene_sequencer scene_sequencer_i (
        .clk_100m, .reset,
        .frame(pos.frame), .busy,
        .rect_pix('{we: rect_drawing, x: rect_x, y: rect_y, cidx: shape.cidx}),
        .rect_done,
        .tri_pix('{we: tri_drawing, x: tri_x, y: tri_y, cidx: shape.cidx}),
        .tri_done,
        .shape, .rect_start, .tri_start, .draw_oe, .fb_wr, .scene_done
    );

    draw_rect_fill draw_rect_fill_i (
        .clk_100m, .reset, .start(rect_start), .oe(draw_oe),
        .x0(shape.x0), .y0(shape.y0), .x1(shape.x1), .y1(shape.y1),
        .x(rect_x), .y(rect_y), .drawing(rect_drawing), .done(rect_done)
    );

    draw_tri_fill draw_tri_fill_i (
        .clk_100m, .reset, .start(tri_start), .oe(draw_oe),
        .x0(shape.x0), .y0(shape.y0), .x1(shape.x1), .y1(shape.y1),
        .x2(shape.x2), .y2(shape.y2),
        .x(tri_x), .y(tri_y), .drawing(tri_drawing), .done(tri_done)
    );

    framebuffer framebuffer_i (.clk_100m, .reset, .pos, .wr(fb_wr), .busy, .vga);
endmodule

// File: hw/display_timing.sv
// display timing generator
// reduced raster counters with sync, data enable and frame strobe
`timescale 1ns/1ns

module display_timing import castle_pkg::*; (
    input  logic        clk_100m,
    input  logic        reset,
    output screen_pos_t pos
);
    coord_t sx, sy;

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_TOTAL - 1) begin  // end of line
            sx <= '0;
            sy <= (sy == V_TOTAL - 1) ? coord_t'(0) : coord_t'(sy + 1);
        end else begin
            sx <= coord_t'(sx + 1);
        end
    end

    always_comb begin
        pos.sx    = sx;
        pos.sy    = sy;
        pos.hsync = (sx >= H_SYNC_START) && (sx < H_SYNC_END);
        pos.vsync = (sy >= V_SYNC_START) && (sy < V_SYNC_END);
        pos.de    = (sx < FB_WIDTH) && (sy < FB_HEIGHT);
        pos.frame = (sx == 0) && (sy == 0);  // one cycle per frame
    end
endmodule

// File: hw/draw_rect_fill.sv
// filled rectangle walker
// emits every pixel from (x0,y0) to (x1,y1) row by row, one per enabled cycle
`timescale 1ns/1ns

module draw_rect_fill import castle_pkg::*; (
    input  logic   clk_100m,
    input  logic   reset,
    input  logic   start,
    input  logic   oe,
    input  coord_t x0, y0, x1, y1,
    output coord_t x, y,
    output logic   drawing,
    output logic   done
);
    coord_t x_beg, x_end, y_end;
    logic   active;
    logic   last;

    assign last    = (x == x_end) && (y == y_end);
    assign drawing = active && oe;

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            active <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active <= 1'b1;
            end else if (drawing && last) begin
                active <= 1'b0;
                done   <= 1'b1;  // one cycle after the last pixel
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        if (start) begin
            x     <= x0;
            y     <= y0;
            x_beg <= x0;
            x_end <= x1;
            y_end <= y1;
        end else if (drawing) begin
            if (x == x_end) begin  // next row
                x <= x_beg;
                y <= coord_t'(y + 1);
            end else begin
                x <= coord_t'(x + 1);
            end
        end
    end
endmodule

// File: hw/draw_tri_fill.sv
// filled triangle walker
// scans the bounding box and flags points on or inside all three edges
// vertices are expected clockwise on screen
`timescale 1ns/1ns

module draw_tri_fill import castle_pkg::*; (
    input  logic   clk_100m,
    input  logic   reset,
    input  logic   start,
    input  logic   oe,
    input  coord_t x0, y0, x1, y1, x2, y2,
    output coord_t x, y,
    output logic   drawing,
    output logic   done
);
    coord_t vx0, vy0, vx1, vy1, vx2, vy2;  // latched vertices
    coord_t x_beg, x_end, y_end;
    logic   active;
    logic   step;
    logic   last;
    logic signed [15:0] e0, e1, e2;

    function automatic coord_t min3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // edge functions, positive on the inner side
    assign e0 = (vx1 - vx0) * (y - vy0) - (vy1 - vy0) * (x - vx0);
    assign e1 = (vx2 - vx1) * (y - vy1) - (vy2 - vy1) * (x - vx1);
    assign e2 = (vx0 - vx2) * (y - vy2) - (vy0 - vy2) * (x - vx2);

    assign step    = active && oe;
    assign last    = (x == x_end) && (y == y_end);
    assign drawing = step && (e0 >= 0) && (e1 >= 0) && (e2 >= 0);

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            active <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active <= 1'b1;
            end else if (step && last) begin
                active <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        if (start) begin
            {vx0, vy0, vx1, vy1, vx2, vy2} <= {x0, y0, x1, y1, x2, y2};
            x     <= min3(x0, x1, x2);  // top-left of bounding box
            y     <= min3(y0, y1, y2);
            x_beg <= min3(x0, x1, x2);
            x_end <= max3(x0, x1, x2);
            y_end <= max3(y0, y1, y2);
        end else if (step) begin
            if (x == x_end) begin
                x <= x_beg;
                y <= coord_t'(y + 1);
            end else begin
                x <= coord_t'(x + 1);
            end
        end
    end
endmodule

// File: hw/framebuffer.sv
// indexed-colour framebuffer
// draw write port, scanout read port and palette lookup to registered vga outputs
`timescale 1ns/1ns

module framebuffer import castle_pkg::*; (
    input  logic        clk_100m,
    input  logic        reset,
    input  screen_pos_t pos,
    input  fb_write_t   wr,
    output logic        busy,
    output vga_out_t    vga
);
    cidx_t               mem [FB_DEPTH];
    logic                clearing;  // reset sweep in progress
    logic [FB_ADDRW-1:0] clr_addr;
    logic [FB_ADDRW-1:0] wr_addr, rd_addr;
    logic                wr_ok;
    cidx_t               rd_cidx;
    logic                hsync_q, vsync_q, de_q;  // aligned with rd_cidx
    logic [11:0]         colr;

    assign wr_ok = wr.we && (wr.x >= 0) && (wr.x < FB_WIDTH)
                         && (wr.y >= 0) && (wr.y < FB_HEIGHT);
    assign wr_addr = FB_ADDRW'(int'(wr.y) * FB_WIDTH + int'(wr.x));
    assign rd_addr = FB_ADDRW'(int'(pos.sy) * FB_WIDTH + int'(pos.sx));
    assign busy    = pos.de || clearing;

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            clearing <= 1'b1;
            clr_addr <= '0;
        end else if (clearing) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == FB_ADDRW'(FB_DEPTH - 1)) clearing <= 1'b0;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (clearing)   mem[clr_addr] <= '0;
        else if (wr_ok) mem[wr_addr]  <= wr.cidx;  // off-screen writes dropped
        if (pos.de)     rd_cidx       <= mem[rd_addr];
    end

    assign colr = PALETTE[rd_cidx];

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            {hsync_q, vsync_q, de_q} <= '0;
            vga <= '0;
        end else begin
            {hsync_q, vsync_q, de_q} <= {pos.hsync, pos.vsync, pos.de};
            vga.hsync <= hsync_q;
            vga.vsync <= vsync_q;
            vga.de    <= de_q;
            vga.r     <= de_q ? colr[11:8] : 4'h0;  // black in blanking
            vga.g     <= de_q ? colr[7:4]  : 4'h0;
            vga.b     <= de_q ? colr[3:0]  : 4'h0;
        end
    end
endmodule

// File: hw/scene_sequencer.sv
// scene sequencer
// steps through the castle scene table, starts the fillers and registers their pixels
`timescale 1ns/1ns

module scene_sequencer import castle_pkg::*; (
    input  logic      clk_100m,
    input  logic      reset,
    input  logic      frame,
    input  logic      busy,
    input  fb_write_t rect_pix,
    input  logic      rect_done,
    input  fb_write_t tri_pix,
    input  logic      tri_done,
    output shape_t    shape,
    output logic      rect_start,
    output logic      tri_start,
    output logic      draw_oe,
    output fb_write_t fb_wr,
    output logic      scene_done
);
    seq_state_e state;
    logic [3:0] shape_id;
    shape_t     entry;       // table entry for shape_id
    fb_write_t  active_pix;  // pixel from whichever filler is drawing

    function automatic shape_t mk_rect(coord_t ax, coord_t ay, coord_t bx, coord_t by,
                                       cidx_t c);
        shape_t s;
        s = '{kind: SHAPE_RECT, x0: ax, y0: ay, x1: bx, y1: by, x2: '0, y2: '0, cidx: c};
        return s;
    endfunction

    function automatic shape_t mk_tri(coord_t ax, coord_t ay, coord_t bx, coord_t by,
                                      coord_t cx, coord_t cy, cidx_t c);
        shape_t s;
        s = '{kind: SHAPE_TRI, x0: ax, y0: ay, x1: bx, y1: by, x2: cx, y2: cy, cidx: c};
        return s;
    endfunction

    // later entries paint over earlier ones
    always_comb begin
        case (shape_id)
            4'd0: entry = mk_rect(12, 24, 51, 40, 4'h5);          // main building
            4'd1: entry = mk_rect(27, 32, 36, 40, 4'h4);          // door in brown
            4'd2: entry = mk_tri(27, 32, 30, 32, 27, 35, 4'h5);   // left arch corner
            4'd3: entry = mk_tri(33, 32, 36, 32, 36, 35, 4'h5);   // right arch corner
            4'd4: entry = mk_rect(6, 14, 12, 40, 4'h5);           // left tower
            4'd5: entry = mk_rect(26, 12, 37, 24, 4'h5);          // middle tower
            4'd6: entry = mk_rect(51, 14, 57, 40, 4'h5);          // right tower
            4'd7: entry = mk_tri(32, 3, 40, 11, 24, 11, 4'h2);    // roof in dark purple
            4'd8: entry = mk_rect(30, 15, 34, 21, 4'h1);          // window in dark blue
            default: entry = mk_tri(2, 2, 8, 8, 2, 8, 4'h7);      // never selected
        endcase
    end

    always_ff @(posedge clk_100m) begin
        if (reset) begin
            state      <= IDLE;
            shape_id   <= '0;
            rect_start <= 1'b0;
            tri_start  <= 1'b0;
        end else begin
            rect_start <= 1'b0;
            tri_start  <= 1'b0;
            case (state)
                IDLE: if (frame) state <= INIT;
                INIT: begin
                    rect_start <= (entry.kind == SHAPE_RECT);
                    tri_start  <= (entry.kind == SHAPE_TRI);
                    state      <= DRAW;
                end
                DRAW: begin
                    if (rect_done || tri_done) begin
                        if (shape_id == 4'(SHAPE_CNT - 1)) begin
                            state <= DONE;
                        end else begin
                            shape_id <= shape_id + 4'd1;
                            state    <= INIT;
                        end
                    end
                end
                default: state <= DONE;  // scene finished, stay here
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == INIT) shape <= entry;  // vertices stable for the whole draw
    end

    assign active_pix = tri_pix.we ? tri_pix : rect_pix;

    // one register stage between filler and framebuffer
    always_ff @(posedge clk_100m) begin
        fb_wr.x    <= active_pix.x;
        fb_wr.y    <= active_pix.y;
        fb_wr.cidx <= active_pix.cidx;
        if (reset) fb_wr.we <= 1'b0;
        else       fb_wr.we <= active_pix.we;
    end

    assign draw_oe    = !busy;
    assign scene_done = (state == DONE);
endmodule

// File: testbench/castle_assert.sv
// sequencer and filler protocol assertions
// bound into scene_sequencer
`timescale 1ns/1ns

module castle_assert import castle_pkg::*; (
    input logic      clk_100m,
    input logic      reset,
    input logic      rect_start,
    input logic      tri_start,
    input logic      busy,
    input fb_write_t rect_pix,
    input fb_write_t tri_pix
);
    start_single_cycle: assert property (@(posedge clk_100m) disable iff (reset)
        (rect_start || tri_start) |=> !(rect_start || tri_start))
        else $error("filler start pulse longer than one cycle");

    start_exclusive: assert property (@(posedge clk_100m) disable iff (reset)
        !(rect_start && tri_start))
        else $error("rect_start and tri_start high together");

    // memory port belongs to scanout while busy
    no_draw_when_busy: assert property (@(posedge clk_100m) disable iff (reset)
        busy |-> !(rect_pix.we || tri_pix.we))
        else $error("filler drawing while framebuffer busy");
endmodule

bind scene_sequencer castle_assert castle_assert_i (
    .clk_100m, .reset, .rect_start, .tri_start, .busy, .rect_pix, .tri_pix
);

// File: testbench/castle_patterns.txt
// probe columns: x, y, expected 12-bit rgb (all hex)
// FFF ends the probes, the word after it is the frame limit for scene_done
014 018 655
014 017 000
033 028 655
033 029 000
01B 028 A53
01F 024 A53
025 024 655
01C 021 655
01E 021 A53
023 021 655
021 021 A53
006 00E 655
005 00E 000
026 014 000
039 028 655
03A 01E 000
020 003 725
018 00B 725
019 009 000
027 009 000
020 012 235
022 015 235
023 012 655
FFF 008

// File: testbench/tb_castle.sv
// castle scene testbench
// captures vga frames, checks raster timing and probe colours from the pattern file
`timescale 1ns/1ns

module tb_castle import castle_pkg::*; ();
    logic     clk_100m;
    logic     reset;
    vga_out_t vga;
    logic     scene_done;

    logic [11:0] pat_mem [128];  // x, y and rgb triples followed by end marker and frame limit
    logic [11:0] cur_frame [FB_WIDTH * FB_HEIGHT];
    logic [11:0] ref_frame [FB_WIDTH * FB_HEIGHT];
    int          errors;
    int          probes;
    int          frames;
    int          frame_limit;
    logic        done_seen;

    castle_top castle_top_i (.clk_100m, .reset, .vga, .scene_done);

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    initial begin
        #1;  // pattern file is loaded at time 0
        #((frame_limit + 5) * H_TOTAL * V_TOTAL * 10);
        $display("watchdog timeout, scene did not finish in %0d frames", frame_limit + 5);
        $display("errors: %0d, probes checked: %0d, frames captured: %0d",
                 errors + 1, probes, frames);
        $display("Regression failed");
        $finish;
    end

    task automatic value_error(input string name, input logic [11:0] got,
                               input logic [11:0] exp);
        errors++;
        $display("FAILED %s got %h expected %h", name, got, exp);
    endtask

    // one full raster from row 0 with pixel position rebuilt from de
    task automatic capture_frame(input logic align);
        int          i;
        int          col;
        int          row;
        int          hsync_rises;
        int          vsync_rises;
        logic        prev_de;
        logic        prev_hs;
        logic        prev_vs;
        logic [11:0] rgb;
        col = 0;
        row = 0;
        hsync_rises = 0;
        vsync_rises = 0;
        prev_de = 1'b0;
        prev_hs = 1'b0;
        prev_vs = 1'b0;
        if (align) begin
            do @(negedge clk_100m); while (!vga.vsync);
        end
        do @(negedge clk_100m); while (!vga.de);
        for (i = 0; i < H_TOTAL * V_TOTAL; i++) begin
            if (i > 0) @(negedge clk_100m);
            rgb = {vga.r, vga.g, vga.b};
            if (scene_done) done_seen = 1'b1;
            if (done_seen && !scene_done) begin
                errors++;
                $display("scene_done dropped after it had risen");
                done_seen = 1'b0;
            end
            if (vga.de) begin
                if (row < FB_HEIGHT && col < FB_WIDTH) cur_frame[row * FB_WIDTH + col] = rgb;
                col++;
            end else if (rgb !== 12'h000) begin
                value_error("vga.rgb in blanking", rgb, 12'h000);
            end
            if (prev_de && !vga.de) begin  // end of an active line
                if (col != FB_WIDTH) value_error("vga.de run", 12'(col), 12'(FB_WIDTH));
                row++;
                col = 0;
            end
            if (vga.hsync && !prev_hs) hsync_rises++;
            if (vga.vsync && !prev_vs) vsync_rises++;
            prev_de = vga.de;
            prev_hs = vga.hsync;
            prev_vs = vga.vsync;
        end
        if (row != FB_HEIGHT) value_error("vga.de lines", 12'(row), 12'(FB_HEIGHT));
        if (hsync_rises != V_TOTAL) value_error("vga.hsync pulses", 12'(hsync_rises),
                                                12'(V_TOTAL));
        if (vsync_rises != 1) value_error("vga.vsync pulses", 12'(vsync_rises), 12'h001);
        frames++;
    endtask

    task automatic check_probes(input logic expect_black);
        int          i;
        int          x;
        int          y;
        logic [11:0] exp;
        i = 0;
        while (i < 120 && pat_mem[i] !== 12'hFFF) begin
            x = int'(pat_mem[i]);
            y = int'(pat_mem[i + 1]);
            exp = expect_black ? 12'h000 : pat_mem[i + 2];
            probes++;
            if (x >= FB_WIDTH || y >= FB_HEIGHT) begin
                errors++;
                $display("probe %0d lies outside the framebuffer", i / 3);
            end else if (cur_frame[y * FB_WIDTH + x] !== exp) begin
                errors++;
                $display("FAILED vga.rgb at (%0d,%0d) got %h expected %h",
                         x, y, cur_frame[y * FB_WIDTH + x], exp);
            end
            i += 3;
        end
    endtask

    initial begin
        int end_idx;
        int phase;
        errors = 0;
        probes = 0;
        frames = 0;
        done_seen = 1'b0;
        reset = 1'b1;
        void'($urandom(32'h0dda214f));
        $readmemh("testbench/castle_patterns.txt", pat_mem);
        end_idx = 0;
        while (end_idx < 120 && pat_mem[end_idx] !== 12'hFFF) end_idx += 3;
        frame_limit = int'(pat_mem[end_idx + 1]);
        repeat (16) @(posedge clk_100m);
        #1 reset = 1'b0;

        capture_frame(1'b0);  // first frame has nothing drawn yet
        check_probes(1'b1);
        if (done_seen) begin
            errors++;
            $display("scene_done was already high in the first frame");
        end
        while (!scene_done && frames < frame_limit) capture_frame(1'b0);
        if (!scene_done) begin
            errors++;
            $display("scene_done did not rise within %0d frames", frame_limit);
        end else begin
            phase = $urandom_range(H_TOTAL * V_TOTAL - 1);  // random start phase
            repeat (phase) @(negedge clk_100m);
            capture_frame(1'b1);
            check_probes(1'b0);
            ref_frame = cur_frame;
            capture_frame(1'b0);
            for (int p = 0; p < FB_WIDTH * FB_HEIGHT; p++) begin
                if (cur_frame[p] !== ref_frame[p]) value_error("vga.rgb frame to frame",
                                                               cur_frame[p], ref_frame[p]);
            end
        end

        $display("errors: %0d, probes checked: %0d, frames captured: %0d",
                 errors, probes, frames);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end
endmodule

// File: vlog.f
hw/castle_pkg.sv
hw/display_timing.sv
hw/draw_rect_fill.sv
hw/draw_tri_fill.sv
hw/framebuffer.sv
hw/scene_sequencer.sv
hw/castle_top.sv
testbench/castle_assert.sv
testbench/tb_castle.sv
